/* design/div_operand_prep.sv */
module div_operand_prep (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      flush,
    input  logic                      start,
    input  logic [div_pkg::XLEN-1:0]  a,
    input  logic [div_pkg::XLEN-1:0]  b,
    input  div_pkg::div_op_e          op,
    input  logic [div_pkg::TAG_W-1:0] tag_in,
    input  logic [div_pkg::XLEN-1:0]  pc_in,
    output logic                      prep_valid,
    output logic [div_pkg::XLEN-1:0]  prep_dividend,
    output logic [div_pkg::XLEN-1:0]  prep_divisor,
    output logic                      prep_neg_quot,
    output logic                      prep_neg_rem,
    output logic                      prep_div_zero,
    output logic                      prep_want_rem,
    output logic [div_pkg::XLEN-1:0]  prep_dividend_raw,
    output logic [div_pkg::TAG_W-1:0] prep_tag,
    output logic [div_pkg::XLEN-1:0]  prep_pc
);
    import div_pkg::*;

    logic            is_signed;
    logic            want_rem;
    logic            a_neg;
    logic            b_neg;
    logic            b_zero;
    logic [XLEN-1:0] a_mag;
    logic [XLEN-1:0] b_mag;

    // Opcode decode
    always_comb begin
        is_signed = 1'b0;
        want_rem  = 1'b0;
        case (op)
            DIV_OP_REMU: want_rem = 1'b1;
            DIV_OP_DIV:  is_signed = 1'b1;
            DIV_OP_REM: begin
                is_signed = 1'b1;
                want_rem  = 1'b1;
            end
            default: ;  // DIVU, illegal codes fall back to it
        endcase
    end

    assign a_neg  = is_signed & a[XLEN-1];
    assign b_neg  = is_signed & b[XLEN-1];
    assign b_zero = (b == '0);
    assign a_mag  = a_neg ? -a : a;  // MIN stays 0x8000_0000 as unsigned
    assign b_mag  = b_neg ? -b : b;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            prep_valid        <= 1'b0;
            prep_dividend     <= '0;
            prep_divisor      <= '0;
            prep_neg_quot     <= 1'b0;
            prep_neg_rem      <= 1'b0;
            prep_div_zero     <= 1'b0;
            prep_want_rem     <= 1'b0;
            prep_dividend_raw <= '0;
            prep_tag          <= '0;
            prep_pc           <= '0;
        end else begin
            prep_valid <= start;  // First issue after a redirect is kept
            if (start) begin
                prep_dividend     <= a_mag;
                prep_divisor      <= b_mag;
                prep_neg_quot     <= (a_neg ^ b_neg) & ~b_zero;
                prep_neg_rem      <= a_neg;
                prep_div_zero     <= b_zero;
                prep_want_rem     <= want_rem;
                prep_dividend_raw <= a;
                prep_tag          <= tag_in;
                prep_pc           <= pc_in;
            end else if (flush) begin
                // Drop stale operands of the squashed path
                prep_dividend     <= '0;
                prep_divisor      <= '0;
                prep_neg_quot     <= 1'b0;
                prep_neg_rem      <= 1'b0;
                prep_div_zero     <= 1'b0;
                prep_want_rem     <= 1'b0;
                prep_dividend_raw <= '0;
                prep_tag          <= '0;
                prep_pc           <= '0;
            end
        end
    end

    a_legal_op: assert property (@(posedge clk) disable iff (reset)
        start |-> op inside {DIV_OP_DIVU, DIV_OP_REMU, DIV_OP_DIV, DIV_OP_REM});

endmodule

/* design/div_pkg.sv */
package div_pkg;

    // ************************************************************
    // Widths and pipeline depth
    // ************************************************************

    localparam int XLEN  = 32;  // Operand and result width
    localparam int TAG_W = 8;   // Physical destination tag

    // One restoring stage per quotient bit
    localparam int DIV_STAGES = XLEN;

    // Prep stage, restoring array, result fix
    localparam int DIV_LATENCY = DIV_STAGES + 2;

    // Side-band carried through the array
    // Four flags, raw dividend, tag and PC
    localparam int DIV_SIDE_W = 4 + XLEN + TAG_W + XLEN;

    // ************************************************************
    // Divide opcodes
    // ************************************************************

    typedef enum logic [3:0] {
        DIV_OP_DIVU = 4'b0001,  // Unsigned quotient
        DIV_OP_REMU = 4'b0010,  // Unsigned remainder
        DIV_OP_DIV  = 4'b0011,  // Signed quotient
        DIV_OP_REM  = 4'b0100   // Signed remainder
    } div_op_e;

endpackage

/* design/div_restoring_array.sv */
module div_restoring_array (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      flush,
    input  logic                      prep_valid,
    input  logic [div_pkg::XLEN-1:0]  prep_dividend,
    input  logic [div_pkg::XLEN-1:0]  prep_divisor,
    input  logic                      prep_neg_quot,
    input  logic                      prep_neg_rem,
    input  logic                      prep_div_zero,
    input  logic                      prep_want_rem,
    input  logic [div_pkg::XLEN-1:0]  prep_dividend_raw,
    input  logic [div_pkg::TAG_W-1:0] prep_tag,
    input  logic [div_pkg::XLEN-1:0]  prep_pc,
    output logic                      arr_valid,
    output logic [div_pkg::XLEN-1:0]  arr_quot,
    output logic [div_pkg::XLEN-1:0]  arr_rem,
    output logic                      arr_neg_quot,
    output logic                      arr_neg_rem,
    output logic                      arr_div_zero,
    output logic                      arr_want_rem,
    output logic [div_pkg::XLEN-1:0]  arr_dividend_raw,
    output logic [div_pkg::TAG_W-1:0] arr_tag,
    output logic [div_pkg::XLEN-1:0]  arr_pc
);
    import div_pkg::*;

    // ************************************************************
    // Per-stage registers
    // ************************************************************

    logic [XLEN-1:0]       rem_q  [DIV_STAGES];  // Partial remainder
    logic [XLEN-1:0]       quo_q  [DIV_STAGES];  // Dividend bits out, quotient bits in
    logic [XLEN-1:0]       dvs_q  [DIV_STAGES];
    logic [DIV_SIDE_W-1:0] side_q [DIV_STAGES];
    logic [DIV_STAGES-1:0] vld_q;

    logic [DIV_SIDE_W-1:0] prep_side;

    assign prep_side = {prep_neg_quot, prep_neg_rem, prep_div_zero, prep_want_rem,
                        prep_dividend_raw, prep_tag, prep_pc};

    for (genvar i = 0; i < DIV_STAGES; i++) begin : g_stage
        logic [XLEN-1:0]       rem_in;
        logic [XLEN-1:0]       quo_in;
        logic [XLEN-1:0]       dvs_in;
        logic [DIV_SIDE_W-1:0] side_in;
        logic                  vld_in;
        logic [XLEN:0]         trial;
        logic [XLEN:0]         diff;
        logic                  fits;

        if (i == 0) begin : g_head
            assign rem_in  = '0;
            assign quo_in  = prep_dividend;
            assign dvs_in  = prep_divisor;
            assign side_in = prep_side;
            assign vld_in  = prep_valid;
        end else begin : g_body
            assign rem_in  = rem_q[i-1];
            assign quo_in  = quo_q[i-1];
            assign dvs_in  = dvs_q[i-1];
            assign side_in = side_q[i-1];
            assign vld_in  = vld_q[i-1];
        end

        // Bring down the next dividend bit and try the subtract
        assign trial = {rem_in, quo_in[XLEN-1]};
        assign diff  = trial - {1'b0, dvs_in};
        assign fits  = (trial >= {1'b0, dvs_in});

        always_ff @(posedge clk or posedge reset) begin
            if (reset) begin
                rem_q[i]  <= '0;
                quo_q[i]  <= '0;
                dvs_q[i]  <= '0;
                side_q[i] <= '0;
                vld_q[i]  <= 1'b0;
            end else begin
                rem_q[i]  <= fits ? diff[XLEN-1:0] : trial[XLEN-1:0];
                quo_q[i]  <= {quo_in[XLEN-2:0], fits};
                dvs_q[i]  <= dvs_in;
                side_q[i] <= side_in;
                vld_q[i]  <= flush ? 1'b0 : vld_in;
            end
        end
    end

    // ************************************************************
    // Tail of the array
    // ************************************************************

    assign arr_quot  = quo_q[DIV_STAGES-1];
    assign arr_rem   = rem_q[DIV_STAGES-1];
    assign arr_valid = vld_q[DIV_STAGES-1] & ~flush;  // Squash the slot leaving this edge too

    assign {arr_neg_quot, arr_neg_rem, arr_div_zero, arr_want_rem,
            arr_dividend_raw, arr_tag, arr_pc} = side_q[DIV_STAGES-1];

    a_valid_known: assert property (@(posedge clk) disable iff (reset)
        !$isunknown(vld_q));

endmodule

/* design/div_result_fix.sv */
module div_result_fix (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      arr_valid,
    input  logic [div_pkg::XLEN-1:0]  arr_quot,
    input  logic [div_pkg::XLEN-1:0]  arr_rem,
    input  logic                      arr_neg_quot,
    input  logic                      arr_neg_rem,
    input  logic                      arr_div_zero,
    input  logic                      arr_want_rem,
    input  logic [div_pkg::XLEN-1:0]  arr_dividend_raw,
    input  logic [div_pkg::TAG_W-1:0] arr_tag,
    input  logic [div_pkg::XLEN-1:0]  arr_pc,
    output logic [div_pkg::XLEN-1:0]  result,
    output logic                      done,
    output logic [div_pkg::TAG_W-1:0] tag_out,
    output logic [div_pkg::XLEN-1:0]  pc_out
);
    import div_pkg::*;

    logic [XLEN-1:0] pick;
    logic            negate;
    logic [XLEN-1:0] fixed;

    always_comb begin
        pick   = arr_want_rem ? arr_rem : arr_quot;
        negate = arr_want_rem ? arr_neg_rem : arr_neg_quot;
        fixed  = negate ? -pick : pick;
        // Zero divisor: quotient all ones, remainder is the dividend
        if (arr_div_zero) begin
            fixed = arr_want_rem ? arr_dividend_raw : '1;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            result  <= '0;
            done    <= 1'b0;
            tag_out <= '0;
            pc_out  <= '0;
        end else begin
            done <= arr_valid;
            if (arr_valid) begin
                result  <= fixed;
                tag_out <= arr_tag;
                pc_out  <= arr_pc;
            end
        end
    end

    // A done pulse carries a fully known result
    a_done_known: assert property (@(posedge clk) disable iff (reset)
        done |-> !$isunknown({result, tag_out, pc_out}));

endmodule

/* design/div_unit.sv */
module div_unit (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      start,
    input  logic                      flush,
    input  logic [div_pkg::XLEN-1:0]  a,
    input  logic [div_pkg::XLEN-1:0]  b,
    input  div_pkg::div_op_e          op,
    input  logic [div_pkg::TAG_W-1:0] tag_in,
    input  logic [div_pkg::XLEN-1:0]  pc_in,
    output logic [div_pkg::XLEN-1:0]  result,
    output logic                      done,
    output logic [div_pkg::TAG_W-1:0] tag_out,
    output logic [div_pkg::XLEN-1:0]  pc_out
);
    import div_pkg::*;

    // Prep stage to array
    logic             prep_valid;
    logic [XLEN-1:0]  prep_dividend;
    logic [XLEN-1:0]  prep_divisor;
    logic             prep_neg_quot;
    logic             prep_neg_rem;
    logic             prep_div_zero;
    logic             prep_want_rem;
    logic [XLEN-1:0]  prep_dividend_raw;
    logic [TAG_W-1:0] prep_tag;
    logic [XLEN-1:0]  prep_pc;

    // Array to result fix
    logic             arr_valid;
    logic [XLEN-1:0]  arr_quot;
    logic [XLEN-1:0]  arr_rem;
    logic             arr_neg_quot;
    logic             arr_neg_rem;
    logic             arr_div_zero;
    logic             arr_want_rem;
    logic [XLEN-1:0]  arr_dividend_raw;
    logic [TAG_W-1:0] arr_tag;
    logic [XLEN-1:0]  arr_pc;

    div_operand_prep u_prep (
        .clk               (clk),
        .reset             (reset),
        .flush             (flush),
        .start             (start),
        .a                 (a),
        .b                 (b),
        .op                (op),
        .tag_in            (tag_in),
        .pc_in             (pc_in),
        .prep_valid        (prep_valid),
        .prep_dividend     (prep_dividend),
        .prep_divisor      (prep_divisor),
        .prep_neg_quot     (prep_neg_quot),
        .prep_neg_rem      (prep_neg_rem),
        .prep_div_zero     (prep_div_zero),
        .prep_want_rem     (prep_want_rem),
        .prep_dividend_raw (prep_dividend_raw),
        .prep_tag          (prep_tag),
        .prep_pc           (prep_pc)
    );

    div_restoring_array u_array (
        .clk               (clk),
        .reset             (reset),
        .flush             (flush),
        .prep_valid        (prep_valid),
        .prep_dividend     (prep_dividend),
        .prep_divisor      (prep_divisor),
        .prep_neg_quot     (prep_neg_quot),
        .prep_neg_rem      (prep_neg_rem),
        .prep_div_zero     (prep_div_zero),
        .prep_want_rem     (prep_want_rem),
        .prep_dividend_raw (prep_dividend_raw),
        .prep_tag          (prep_tag),
        .prep_pc           (prep_pc),
        .arr_valid         (arr_valid),
        .arr_quot          (arr_quot),
        .arr_rem           (arr_rem),
        .arr_neg_quot      (arr_neg_quot),
        .arr_neg_rem       (arr_neg_rem),
        .arr_div_zero      (arr_div_zero),
        .arr_want_rem      (arr_want_rem),
        .arr_dividend_raw  (arr_dividend_raw),
        .arr_tag           (arr_tag),
        .arr_pc            (arr_pc)
    );

    div_result_fix u_fix (
        .clk              (clk),
        .reset            (reset),
        .arr_valid        (arr_valid),
        .arr_quot         (arr_quot),
        .arr_rem          (arr_rem),
        .arr_neg_quot     (arr_neg_quot),
        .arr_neg_rem      (arr_neg_rem),
        .arr_div_zero     (arr_div_zero),
        .arr_want_rem     (arr_want_rem),
        .arr_dividend_raw (arr_dividend_raw),
        .arr_tag          (arr_tag),
        .arr_pc           (arr_pc),
        .result           (result),
        .done             (done),
        .tag_out          (tag_out),
        .pc_out           (pc_out)
    );

endmodule

/* dv/div_unit_tb.sv */
module div_unit_tb;
    import div_pkg::*;

    localparam int MAX_ROWS   = 80;
    localparam int NUM_RANDOM = 40;

    typedef struct packed {
        logic [XLEN-1:0]  result;
        logic [TAG_W-1:0] tag;
        logic [XLEN-1:0]  pc;
        logic [31:0]      done_edge;  // Edge count at which done is expected
    } expect_t;

    logic             clk;
    logic             reset;
    logic             start;
    logic             flush;
    logic [XLEN-1:0]  a;
    logic [XLEN-1:0]  b;
    div_op_e          op;
    logic [TAG_W-1:0] tag_in;
    logic [XLEN-1:0]  pc_in;
    logic [XLEN-1:0]  result;
    logic             done;
    logic [TAG_W-1:0] tag_out;
    logic [XLEN-1:0]  pc_out;

    // Stimulus table: opcode, operands, idle cycles before a flush
    div_op_e         op_tab [MAX_ROWS];
    logic [XLEN-1:0] a_tab  [MAX_ROWS];
    logic [XLEN-1:0] b_tab  [MAX_ROWS];
    int              fl_tab [MAX_ROWS];
    int              num_rows;
    int              idle_total;
    logic [31:0]     rand_state;
    logic [31:0]     edge_cnt;
    expect_t         exp_q [$];
    expect_t         head;

    div_unit UUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) edge_cnt <= edge_cnt + 1;

    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    // Truncating division with the zero-divisor and overflow rules
    function automatic logic [XLEN-1:0] ref_divide(div_op_e f_op, logic [XLEN-1:0] x,
                                                   logic [XLEN-1:0] y);
        logic signed [XLEN-1:0] sx;
        logic signed [XLEN-1:0] sy;
        logic                   ovf;
        sx  = x;
        sy  = y;
        ovf = (x == {1'b1, {(XLEN-1){1'b0}}}) && (y == '1);
        if (f_op == DIV_OP_DIVU) return (y == '0) ? '1 : x / y;
        if (f_op == DIV_OP_REMU) return (y == '0) ? x : x % y;
        if (f_op == DIV_OP_DIV) begin
            if (y == '0) return '1;
            if (ovf) return x;
            return sx / sy;
        end
        if (y == '0) return x;
        if (ovf) return '0;
        return sx % sy;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] want);
        if (got !== want) begin
            fail_run($sformatf("Fail at %0t: %s is %h, expected %h", $time, name, got, want));
        end
    endtask

    task automatic add_row(input div_op_e r_op, input logic [XLEN-1:0] r_a,
                           input logic [XLEN-1:0] r_b, input int r_fl);
        op_tab[num_rows] = r_op;
        a_tab[num_rows]  = r_a;
        b_tab[num_rows]  = r_b;
        fl_tab[num_rows] = r_fl;
        num_rows         = num_rows + 1;
        idle_total       = idle_total + r_fl;
    endtask

    // ************************************************************
    // Stimulus table
    // ************************************************************

    task automatic build_table();
        logic [31:0] r;
        logic [31:0] ra;
        logic [31:0] rb;
        add_row(DIV_OP_DIVU, 32'd100, 32'd7, 0);
        add_row(DIV_OP_REMU, 32'd100, 32'd7, 0);
        add_row(DIV_OP_DIVU, 32'd0, 32'd1, 0);
        add_row(DIV_OP_DIVU, 32'hFFFF_FFFF, 32'd1, 0);
        add_row(DIV_OP_REMU, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 0);
        add_row(DIV_OP_DIVU, 32'd1, 32'hFFFF_FFFF, 0);
        add_row(DIV_OP_DIVU, 32'h1234_5678, 32'd0, 0);  // Zero divisor
        add_row(DIV_OP_REMU, 32'h1234_5678, 32'd0, 0);
        add_row(DIV_OP_DIV, -32'd7, 32'd2, 0);
        add_row(DIV_OP_REM, -32'd7, 32'd2, 0);
        add_row(DIV_OP_DIV, 32'd7, -32'd2, 0);
        add_row(DIV_OP_REM, 32'd7, -32'd2, 0);
        add_row(DIV_OP_DIV, -32'd7, -32'd2, 0);
        add_row(DIV_OP_REM, -32'd7, -32'd2, 0);
        add_row(DIV_OP_DIV, -32'd5, 32'd0, 0);
        add_row(DIV_OP_REM, -32'd5, 32'd0, 0);
        add_row(DIV_OP_DIV, 32'h8000_0000, 32'hFFFF_FFFF, 0);  // Signed overflow
        add_row(DIV_OP_REM, 32'h8000_0000, 32'hFFFF_FFFF, 0);
        add_row(DIV_OP_DIV, 32'h8000_0000, 32'd1, 40);  // Flush with the pipe empty
        add_row(DIV_OP_DIVU, 32'd1000, 32'd10, 0);
        add_row(DIV_OP_REM, -32'd1000, 32'd3, 0);
        add_row(DIV_OP_DIV, 32'd123456, -32'd789, 4);  // Three in flight are squashed
        add_row(DIV_OP_REMU, 32'hDEAD_BEEF, 32'h1234, 32);  // Squashed in the tail slot
        add_row(DIV_OP_DIVU, 32'hDEAD_BEEF, 32'h1234, 33);  // Leaves just before the flush
        add_row(DIV_OP_DIV, 32'h7FFF_FFFF, 32'hFFFF_FFFF, 0);
        for (int k = 0; k < NUM_RANDOM; k++) begin
            r  = next_rand();
            ra = next_rand();
            rb = next_rand() >> r[6:2];  // Spread divisor sizes
            add_row(div_op_e'({2'b00, r[1:0]} + 4'd1), ra, rb, 0);
        end
    endtask

    task automatic issue_row(input int idx, input logic with_flush);
        expect_t e;
        if (with_flush) begin
            // Anything due on or after the flush edge never completes
            while (exp_q.size() != 0 && exp_q[$].done_edge > edge_cnt) begin
                exp_q.delete(exp_q.size() - 1);
            end
        end
        start       = 1'b1;
        flush       = with_flush;
        op          = op_tab[idx];
        a           = a_tab[idx];
        b           = b_tab[idx];
        tag_in      = idx;
        pc_in       = 32'h0000_1000 + 4 * idx;
        e.result    = ref_divide(op_tab[idx], a_tab[idx], b_tab[idx]);
        e.tag       = idx;
        e.pc        = pc_in;
        e.done_edge = edge_cnt + DIV_LATENCY;
        exp_q.push_back(e);
    endtask

    // ************************************************************
    // Main sequence, monitor and watchdog
    // ************************************************************

    initial begin
        logic flush_next;
        reset      = 1'b1;
        start      = 1'b0;
        flush      = 1'b0;
        a          = '0;
        b          = '0;
        op         = DIV_OP_DIVU;
        tag_in     = '0;
        pc_in      = '0;
        edge_cnt   = '0;
        rand_state = 32'h4083_304c;
        num_rows   = 0;
        idle_total = 0;
        flush_next = 1'b0;
        build_table();
        repeat (8) @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < num_rows; i++) begin
            issue_row(i, flush_next);
            @(negedge clk);
            flush_next = (fl_tab[i] != 0);
            if (flush_next) begin
                start = 1'b0;
                flush = 1'b0;
                repeat (fl_tab[i]) @(negedge clk);
            end
        end
        start = 1'b0;
        flush = 1'b0;
        repeat (2 * DIV_LATENCY) @(negedge clk);  // Last done plus room for a stray one
        if (exp_q.size() == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            fail_run("Operations were still pending at the end of the run");
        end
    end

    always @(negedge clk) begin
        if (!reset && done) begin
            if (exp_q.size() == 0) begin
                fail_run("done pulsed with no operation in flight");
            end else begin
                head = exp_q.pop_front();
                check_value("done edge", edge_cnt, head.done_edge);
                check_value("result", result, head.result);
                check_value("tag_out", tag_out, head.tag);
                check_value("pc_out", pc_out, head.pc);
            end
        end
    end

    initial begin
        #1;
        #((num_rows + idle_total + DIV_LATENCY + 100) * 10);
        fail_run("Watchdog expired before all operations completed");
    end

endmodule

/* sim.f */
design/div_pkg.sv
design/div_operand_prep.sv
design/div_restoring_array.sv
design/div_result_fix.sv
design/div_unit.sv
dv/div_unit_tb.sv
